/* build.f */
cachePkg.sv
cpuBusPort.sv
cacheController.sv
cacheArrays.sv
lruTree.sv
dramBurstPort.sv
cacheTop.sv
dramModel.sv
cacheTb.sv

/* cacheTb.sv */
//////////////////////////////
// Read cache testbench
//////////////////////////////

`timescale 1ns/1ps

module cacheTb;

	// one table row
	typedef struct packed {
		logic           isWrite;
		logic [31:0]    address;
		cachePkg::dataT writeData;
		cachePkg::dataT expData;                // ignored on writes
		logic [31:0]    expCount;               // DRAM requests after this row
	} entryT;

	logic              Clock;
	logic              Reset_L;
	logic              cpuReq;
	cachePkg::cpuCmdT  cpuCmd;
	logic              cpuAck;
	cachePkg::dataT    cpuReadData;
	logic              dramReq;
	logic              dramAck;
	logic              dramWordValid;
	cachePkg::dramCmdT dramCmd;
	cachePkg::dataT    dramReadData;
	int                reqCount;
	int                cycles = 0;
	int                cycleLimit = 1000000; // replaced once the table is built

	entryT stimTable [$];

	// reference cache, kept at the level of the replacement rules
	cachePkg::tagT  refTag   [cachePkg::NumWays][cachePkg::NumSets];
	logic           refValid [cachePkg::NumWays][cachePkg::NumSets];
	cachePkg::lruT  refTree  [cachePkg::NumSets];
	cachePkg::dataT refMem   [logic [30:0]]; // words written by the cpu

	cacheTop uut (.Clock, .Reset_L, .cpuReq, .cpuCmd, .dramAck, .dramWordValid,
		.dramReadData, .cpuAck, .cpuReadData, .dramReq, .dramCmd);

	dramModel dram (.Clock, .dramReq, .dramCmd, .dramAck, .dramWordValid,
		.dramReadData, .reqCount);

	initial begin
		Clock = 1'b0;
		forever #50 Clock = ~Clock;             // 100 ns period
	end

	always @(posedge Clock) begin
		cycles = cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("timeout: test did not finish within %0d clock cycles", cycleLimit);
			$display("TESTBENCH FAILED");
			$fatal(1, "run stopped on timeout");
		end
	end

	//////////////////////////////
	// compare tasks
	//////////////////////////////

	task automatic checkData(input string name, input cachePkg::dataT got,
		input cachePkg::dataT exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic checkCount(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("[ERROR] %0t ns %s got %0d expected %0d", $time, name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	//////////////////////////////
	// reference model
	//////////////////////////////

	function automatic cachePkg::dataT memWord(input logic [31:0] addr);
		if (refMem.exists(addr[31:1]))
			return refMem[addr[31:1]];
		return (addr[15:0] >> 1) ^ 16'hA5C3;    // DRAM fill pattern
	endfunction

	// bit 0 picks the pair, bit 1 or bit 2 the way inside it
	function automatic cachePkg::wayT pickVictim(input cachePkg::lruT t);
		return t[0] ? {1'b1, t[2]} : {1'b0, t[1]};
	endfunction

	// point away from the used way, other pair untouched
	function automatic cachePkg::lruT touchTree(input cachePkg::lruT t, input cachePkg::wayT w);
		cachePkg::lruT n;
		n = t;
		n[0] = !w[1];
		if (w[1])
			n[2] = !w[0];
		else
			n[1] = !w[0];
		return n;
	endfunction

	task automatic predictExpected();
		entryT         e;
		cachePkg::tagT tag;
		logic [2:0]    idx;
		int            way;
		int            count;
		count = 0;
		for (int s = 0; s < cachePkg::NumSets; s++) begin
			refTree[s] = '0;
			for (int w = 0; w < cachePkg::NumWays; w++)
				refValid[w][s] = 1'b0;          // all invalid after the sweep
		end
		foreach (stimTable[i]) begin
			e   = stimTable[i];
			tag = e.address[31:7];
			idx = e.address[6:4];
			way = -1;
			for (int w = 0; w < cachePkg::NumWays; w++)
				if (refValid[w][idx] && refTag[w][idx] == tag)
					way = w;
			if (e.isWrite) begin
				count++;                        // write-through, no allocate
				refMem[e.address[31:1]] = e.writeData;
				if (way >= 0)
					refValid[way][idx] = 1'b0;  // drop line on a write hit
			end else begin
				if (way < 0) begin
					way = pickVictim(refTree[idx]);
					refTag[way][idx]   = tag;
					refValid[way][idx] = 1'b1;
					count++;                    // one burst per miss
				end
				refTree[idx] = touchTree(refTree[idx], cachePkg::wayT'(way));
				e.expData = memWord(e.address);
			end
			e.expCount = count;
			stimTable[i] = e;
		end
	endtask

	//////////////////////////////
	// stimulus
	//////////////////////////////

	task automatic addEntry(input logic isWrite, input logic [31:0] address,
		input cachePkg::dataT writeData);
		entryT e;
		e = '0;
		e.isWrite   = isWrite;
		e.address   = address;
		e.writeData = writeData;
		stimTable.push_back(e);
	endtask

	task automatic buildTable();
		addEntry(1'b0, 32'h0000_0050, '0);      // cold miss, set 5
		addEntry(1'b0, 32'h0000_005A, '0);      // other word, same line
		addEntry(1'b0, 32'h0000_1024, '0);      // set 2, tag A
		addEntry(1'b0, 32'h0000_2020, '0);      // tag B
		addEntry(1'b0, 32'h0000_3026, '0);      // tag C
		addEntry(1'b0, 32'h0004_002E, '0);      // tag D, set full
		addEntry(1'b0, 32'h0000_1026, '0);      // touch A again
		addEntry(1'b0, 32'h0010_0022, '0);      // tag E evicts per tree
		addEntry(1'b0, 32'h0000_2020, '0);      // evicted tag
		addEntry(1'b0, 32'h0000_1024, '0);      // kept tag
		addEntry(1'b1, 32'h0000_1024, 16'h1234); // write hit
		addEntry(1'b0, 32'h0000_1024, '0);
		addEntry(1'b1, 32'h0000_7770, 16'hBEEF); // write to uncached line
		addEntry(1'b0, 32'h0000_7770, '0);
		addEntry(1'b0, 32'h0000_7772, '0);
		addEntry(1'b0, 32'h0000_005A, '0);      // first line still there
	endtask

	task automatic step();
		@(posedge Clock);
		#1;
	endtask

	// one four-phase cpu transfer with its checks
	task automatic runTransfer(input entryT e);
		cachePkg::cpuCmdT cmd;
		cmd.isWrite    = e.isWrite;
		cmd.tag        = e.address[31:7];
		cmd.index      = e.address[6:4];
		cmd.wordIdx    = e.address[3:1];
		cmd.writeData  = e.writeData;
		cmd.byteEnable = 2'b11;
		cpuCmd = cmd;
		cpuReq = 1'b1;
		do
			step();
		while (!cpuAck);
		if (!e.isWrite)
			checkData("cpuReadData", cpuReadData, e.expData);
		checkCount("dramReq count", reqCount, int'(e.expCount));
		cpuReq = 1'b0;
		do
			step();
		while (cpuAck);                         // cmd may change from here
	endtask

	initial begin
		Reset_L = 1'b0;
		cpuReq  = 1'b0;
		cpuCmd  = '0;
		buildTable();
		predictExpected();
		cycleLimit = stimTable.size() * 60 + 200;
		repeat (8)
			@(posedge Clock);
		#1 Reset_L = 1'b1;
		foreach (stimTable[i])
			runTransfer(stimTable[i]);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* dramModel.sv */
//////////////////////////////
// DRAM model
//////////////////////////////

`timescale 1ns/1ps

module dramModel (
	input  logic              Clock,
	input  logic              dramReq,
	input  cachePkg::dramCmdT dramCmd,
	output logic              dramAck,
	output logic              dramWordValid,      // one pulse per burst word
	output cachePkg::dataT    dramReadData,
	output int                reqCount            // one per dramReq rising edge
);

	cachePkg::dataT mem [logic [30:0]];         // written words only, keyed by word address
	logic [7:0]     lfsr = 8'd87;               // gap source

	// x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsrStep(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	// two bits, one LFSR step per bit
	function automatic int nextGap();
		int g;
		g = 0;
		for (int i = 0; i < 2; i++) begin
			g = (g << 1) | int'(lfsr[7]);
			lfsr = lfsrStep(lfsr);
		end
		return g;
	endfunction

	// unwritten words follow the address pattern
	function automatic cachePkg::dataT wordAt(input logic [31:0] addr);
		if (mem.exists(addr[31:1]))
			return mem[addr[31:1]];
		return (addr[15:0] >> 1) ^ 16'hA5C3;
	endfunction

	function automatic void storeWord(input cachePkg::dramCmdT cmd);
		cachePkg::dataT merged;
		merged = wordAt(cmd.address);
		if (cmd.byteEnable[1])
			merged[15:8] = cmd.writeData[15:8];   // upper lane
		if (cmd.byteEnable[0])
			merged[7:0] = cmd.writeData[7:0];
		mem[cmd.address[31:1]] = merged;
	endfunction

	task automatic step();
		@(posedge Clock);
		#1;                                     // act just after the edge
	endtask

	initial begin
		cachePkg::dramCmdT cmd;
		int                gap;
		dramAck       = 1'b0;
		dramWordValid = 1'b0;
		dramReadData  = '0;
		reqCount      = 0;
		forever begin
			step();
			if (dramReq) begin
				cmd = dramCmd;
				reqCount++;
				if (cmd.op == cachePkg::dramBurstRead) begin
					// words 0..7 in order, random gaps between them
					for (int w = 0; w < cachePkg::WordsPerLine; w++) begin
						gap = nextGap();
						repeat (gap)
							step();
						dramReadData  = wordAt(cmd.address + 2 * w);
						dramWordValid = 1'b1;
						step();
						dramWordValid = 1'b0;
					end
				end else begin
					storeWord(cmd);             // single word write
				end
				dramAck = 1'b1;
				do
					step();
				while (dramReq);                // hold ack until req falls
				dramAck = 1'b0;
			end
		end
	end

endmodule

/* cacheTop.sv */
//////////////////////////////
// Read cache top
//////////////////////////////

`timescale 1ns/1ps

module cacheTop (
	input  logic              Clock,
	input  logic              Reset_L,
	input  logic              cpuReq,
	input  cachePkg::cpuCmdT  cpuCmd,
	input  logic              dramAck,
	input  logic              dramWordValid,
	input  cachePkg::dataT    dramReadData,
	output logic              cpuAck,
	output cachePkg::dataT    cpuReadData,
	output logic              dramReq,
	output cachePkg::dramCmdT dramCmd
);

	// cpu port to controller
	logic              reqValid, respond;
	cachePkg::cpuCmdT  heldCmd;
	cachePkg::dataT    respondData;
	// controller to arrays and tree
	logic              hit, clearWe, tagWe, invalidateWe, touchWe;
	cachePkg::wayT     hitWay, victimWay, fillWay, invalidateWay, touchWay;
	cachePkg::dataT    lookupData;
	cachePkg::indexT   clearIndex;
	// controller and DRAM port
	logic              start, done, fillWe;
	cachePkg::dramCmdT startCmd;
	cachePkg::wordIdxT fillWord;
	cachePkg::dataT    fillData;

	//////////////////////////////
	// input side
	//////////////////////////////

	cpuBusPort uCpuPort (.Clock, .Reset_L, .cpuReq, .cpuCmd, .respond, .respondData,
		.cpuAck, .cpuReadData, .reqValid, .heldCmd);

	// processing
	cacheController uCtrl (.Clock, .Reset_L, .reqValid, .heldCmd, .hit, .hitWay,
		.lookupData, .victimWay, .done, .respond, .respondData, .clearIndex, .clearWe,
		.tagWe, .fillWay, .invalidateWe, .invalidateWay, .touchWe, .touchWay,
		.start, .startCmd);

	cacheArrays uArrays (.Clock, .Reset_L, .lookupCmd(heldCmd), .clearIndex, .clearWe,
		.tagWe, .fillWay, .invalidateWe, .invalidateWay, .fillWe, .fillWord, .fillData,
		.hit, .hitWay, .lookupData);

	lruTree uLru (.Clock, .Reset_L, .setIndex(clearIndex), .clearWe, .touchWe,
		.touchWay, .victimWay);

	// output side
	dramBurstPort uDramPort (.Clock, .Reset_L, .start, .startCmd, .dramAck,
		.dramWordValid, .dramReadData, .dramReq, .dramCmd, .done, .fillWe,
		.fillWord, .fillData);

endmodule

/* dramBurstPort.sv */
//////////////////////////////
// DRAM side burst port
//////////////////////////////

`timescale 1ns/1ps

module dramBurstPort (
	input  logic               Clock,
	input  logic               Reset_L,
	input  logic               start,           // one-cycle kick from the controller
	input  cachePkg::dramCmdT  startCmd,
	input  logic               dramAck,
	input  logic               dramWordValid,   // one pulse per burst word
	input  cachePkg::dataT     dramReadData,
	output logic               dramReq,
	output cachePkg::dramCmdT  dramCmd,
	output logic               done,
	output logic               fillWe,
	output cachePkg::wordIdxT  fillWord,
	output cachePkg::dataT     fillData
);

	logic              waitRelease;             // req dropped, waiting for ack low
	cachePkg::wordIdxT wordCount;               // next word of the line
	logic              takeWord;

	assign takeWord = dramReq && dramWordValid && (dramCmd.op == cachePkg::dramBurstRead);

	//////////////////////////////
	// request half of the handshake
	//////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			dramReq     <= 1'b0;
			waitRelease <= 1'b0;
			done        <= 1'b0;
			fillWe      <= 1'b0;
			wordCount   <= '0;
		end else begin
			done   <= 1'b0;
			fillWe <= takeWord;                 // strobe one cycle after the word
			if (start) begin
				dramReq   <= 1'b1;
				wordCount <= '0;
			end else if (dramReq && dramAck) begin
				dramReq     <= 1'b0;
				waitRelease <= 1'b1;
			end else if (waitRelease && !dramAck) begin
				waitRelease <= 1'b0;
				done        <= 1'b1;            // back to idle on both sides
			end
			if (takeWord)
				wordCount <= wordCount + 1'b1;  // wraps after word 7
		end
	end

	// command held stable for the whole transfer
	always_ff @(posedge Clock) begin
		if (start)
			dramCmd <= startCmd;
	end

	// fill word and its slot
	always_ff @(posedge Clock) begin
		if (takeWord) begin
			fillWord <= wordCount;
			fillData <= dramReadData;
		end
	end

endmodule

/* lruTree.sv */
//////////////////////////////
// Pseudo-LRU tree
//////////////////////////////

`timescale 1ns/1ps

module lruTree (
	input  logic            Clock,
	input  logic            Reset_L,
	input  cachePkg::indexT setIndex,
	input  logic            clearWe,          // invalidation sweep
	input  logic            touchWe,
	input  cachePkg::wayT   touchWay,
	output cachePkg::wayT   victimWay
);

	cachePkg::lruT lruMem [cachePkg::NumSets];
	cachePkg::lruT curTree;
	cachePkg::lruT touchedTree;

	assign curTree = lruMem[setIndex];

	// bit 0 picks the pair, bits 1 and 2 pick inside pair 0 and pair 1
	always_comb begin
		if (curTree[0])
			victimWay = curTree[2] ? 2'd3 : 2'd2;
		else
			victimWay = curTree[1] ? 2'd1 : 2'd0;
	end

	// point away from the touched way, the other pair bit is kept
	always_comb begin
		touchedTree    = curTree;
		touchedTree[0] = ~touchWay[1];
		if (touchWay[1])
			touchedTree[2] = ~touchWay[0];
		else
			touchedTree[1] = ~touchWay[0];
	end

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L)
			lruMem <= '{default: '0};
		else if (clearWe)
			lruMem[setIndex] <= '0;
		else if (touchWe)
			lruMem[setIndex] <= touchedTree;
	end

endmodule

/* cacheArrays.sv */
//////////////////////////////
// Tag valid and data store
//////////////////////////////

`timescale 1ns/1ps

module cacheArrays (
	input  logic               Clock,
	input  logic               Reset_L,
	input  cachePkg::cpuCmdT   lookupCmd,       // held cpu command
	input  cachePkg::indexT    clearIndex,
	input  logic               clearWe,
	input  logic               tagWe,
	input  cachePkg::wayT      fillWay,
	input  logic               invalidateWe,
	input  cachePkg::wayT      invalidateWay,
	input  logic               fillWe,
	input  cachePkg::wordIdxT  fillWord,
	input  cachePkg::dataT     fillData,
	output logic               hit,
	output cachePkg::wayT      hitWay,
	output cachePkg::dataT     lookupData
);

	// storage, way by set (by word)
	cachePkg::tagT  tagMem  [cachePkg::NumWays][cachePkg::NumSets];
	cachePkg::dataT dataMem [cachePkg::NumWays][cachePkg::NumSets][cachePkg::WordsPerLine];
	logic [cachePkg::NumSets-1:0] validBits [cachePkg::NumWays];

	cachePkg::indexT idx;
	logic            hitAny;                    // compare result before the register
	cachePkg::wayT   hitSel;
	cachePkg::wayT   readWay;                   // hit way, else the fill way

	assign idx = lookupCmd.index;

	//////////////////////////////
	// hit compare over all ways
	//////////////////////////////

	always_comb begin
		hitAny = 1'b0;
		hitSel = '0;
		for (int w = 0; w < cachePkg::NumWays; w++) begin
			if (validBits[w][idx] && (tagMem[w][idx] == lookupCmd.tag)) begin
				hitAny = 1'b1;
				hitSel = cachePkg::wayT'(w);
			end
		end
	end

	assign readWay = hitAny ? hitSel : fillWay;

	// valid bits, cleared by reset, the sweep or a write hit
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			validBits <= '{default: '0};
		end else begin
			if (clearWe)
				for (int w = 0; w < cachePkg::NumWays; w++)
					validBits[w][clearIndex] <= 1'b0;
			if (tagWe)
				validBits[fillWay][idx] <= 1'b1;    // line claimed at fill start
			if (invalidateWe)
				validBits[invalidateWay][idx] <= 1'b0;
		end
	end

	always_ff @(posedge Clock) begin
		if (tagWe)
			tagMem[fillWay][idx] <= lookupCmd.tag;
		if (fillWe)
			dataMem[fillWay][idx][fillWord] <= fillData;   // one burst word
	end

	// registered lookup result
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L)
			hit <= 1'b0;
		else
			hit <= hitAny;
	end

	always_ff @(posedge Clock) begin
		hitWay     <= hitSel;
		lookupData <= dataMem[readWay][idx][lookupCmd.wordIdx];
	end

endmodule

/* cacheController.sv */
//////////////////////////////
// Cache control FSM
//////////////////////////////

`timescale 1ns/1ps

module cacheController (
	input  logic                Clock,
	input  logic                Reset_L,
	input  logic                reqValid,
	input  cachePkg::cpuCmdT    heldCmd,
	input  logic                hit,            // registered lookup result
	input  cachePkg::wayT       hitWay,
	input  cachePkg::dataT      lookupData,
	input  cachePkg::wayT       victimWay,      // from the LRU tree
	input  logic                done,           // DRAM transfer closed
	output logic                respond,
	output cachePkg::dataT      respondData,
	output cachePkg::indexT     clearIndex,     // swept set, else the held set
	output logic                clearWe,
	output logic                tagWe,
	output cachePkg::wayT       fillWay,
	output logic                invalidateWe,
	output cachePkg::wayT       invalidateWay,
	output logic                touchWe,
	output cachePkg::wayT       touchWay,
	output logic                start,
	output cachePkg::dramCmdT   startCmd
);

	cachePkg::ctrlStateT state, nextState;
	cachePkg::indexT     sweepIndex;            // set being invalidated
	cachePkg::wayT       victimReg;             // way chosen for the fill
	logic                issued;                // DRAM request already started
	logic                responded;             // current request already answered

	//////////////////////////////
	// state and control registers
	//////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state      <= cachePkg::stReset;
			sweepIndex <= '0;
			victimReg  <= '0;
			issued     <= 1'b0;
			responded  <= 1'b0;
		end else begin
			state <= nextState;
			if (state == cachePkg::stInvalidate)
				sweepIndex <= sweepIndex + 1'b1;
			if (state == cachePkg::stLookup)
				victimReg <= victimWay;         // latched before the touch moves it
			if (start)
				issued <= 1'b1;
			else if (done)
				issued <= 1'b0;
			if (respond)
				responded <= 1'b1;
			else if (!reqValid)
				responded <= 1'b0;              // port has closed the transfer
		end
	end

	//////////////////////////////
	// next state and outputs
	//////////////////////////////

	always_comb begin
		nextState     = state;
		respond       = 1'b0;
		clearWe       = 1'b0;
		tagWe         = 1'b0;
		invalidateWe  = 1'b0;
		touchWe       = 1'b0;
		touchWay      = victimReg;
		start         = 1'b0;
		case (state)
			cachePkg::stReset: nextState = cachePkg::stInvalidate;
			cachePkg::stInvalidate: begin
				clearWe = 1'b1;                 // valid bits and tree of one set
				if (sweepIndex == cachePkg::indexT'(cachePkg::NumSets - 1))
					nextState = cachePkg::stIdle;
			end
			cachePkg::stIdle: begin
				if (reqValid && !responded)
					nextState = cachePkg::stLookup;
			end
			cachePkg::stLookup: begin
				if (heldCmd.isWrite) begin
					nextState = cachePkg::stWrite;  // never allocates
				end else if (hit) begin
					touchWe   = 1'b1;
					touchWay  = hitWay;
					nextState = cachePkg::stHitRespond;
				end else begin
					nextState = cachePkg::stFill;
				end
			end
			cachePkg::stHitRespond: begin
				respond   = 1'b1;
				nextState = cachePkg::stIdle;
			end
			cachePkg::stFill: begin
				if (!issued) begin
					tagWe   = 1'b1;             // tag + valid for the victim way
					touchWe = 1'b1;
					start   = 1'b1;
				end
				if (done)
					nextState = cachePkg::stFillRespond;  // arrays re-read the word
			end
			cachePkg::stFillRespond: begin
				respond   = 1'b1;
				nextState = cachePkg::stIdle;
			end
			cachePkg::stWrite: begin
				if (!issued) begin
					start        = 1'b1;
					invalidateWe = hit;         // drop the stale line on a hit
				end
				if (done) begin
					respond   = 1'b1;
					nextState = cachePkg::stIdle;
				end
			end
			default: nextState = cachePkg::stReset;
		endcase
	end

	assign respondData   = lookupData;
	assign fillWay       = victimReg;
	assign invalidateWay = hitWay;
	assign clearIndex    = (state == cachePkg::stInvalidate) ? sweepIndex : heldCmd.index;

	// DRAM command, line aligned burst or the exact word on a write
	always_comb begin
		startCmd.writeData = heldCmd.writeData;
		if (heldCmd.isWrite) begin
			startCmd.op         = cachePkg::dramWrite;
			startCmd.address    = {heldCmd.tag, heldCmd.index, heldCmd.wordIdx, 1'b0};
			startCmd.byteEnable = heldCmd.byteEnable;
		end else begin
			startCmd.op         = cachePkg::dramBurstRead;
			startCmd.address    = {heldCmd.tag, heldCmd.index, 4'b0000};
			startCmd.byteEnable = 2'b11;        // reads are always full words
		end
	end

endmodule

/* cpuBusPort.sv */
//////////////////////////////
// CPU side bus port
//////////////////////////////

`timescale 1ns/1ps

module cpuBusPort (
	input  logic             Clock,
	input  logic             Reset_L,
	input  logic             cpuReq,            // four-phase request from the cpu
	input  cachePkg::cpuCmdT cpuCmd,
	input  logic             respond,           // one-cycle pulse from the controller
	input  cachePkg::dataT   respondData,
	output logic             cpuAck,
	output cachePkg::dataT   cpuReadData,
	output logic             reqValid,          // request captured and still open
	output cachePkg::cpuCmdT heldCmd
);

	logic capture;                              // first cycle cpuReq is seen
	logic withdraw;                             // cpu has withdrawn after our ack

	assign capture  = cpuReq && !reqValid;
	assign withdraw = cpuAck && !cpuReq;

	// handshake state
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			reqValid <= 1'b0;
			cpuAck   <= 1'b0;
		end else begin
			if (capture)
				reqValid <= 1'b1;
			else if (withdraw)
				reqValid <= 1'b0;               // ready for the next request

			if (respond)
				cpuAck <= 1'b1;                 // ack the cycle after respond
			else if (withdraw)
				cpuAck <= 1'b0;                 // phase four
		end
	end

	// command copy held until the transfer has closed
	always_ff @(posedge Clock) begin
		if (capture)
			heldCmd <= cpuCmd;
	end

	// read data is meaningless for a write
	always_ff @(posedge Clock) begin
		if (respond)
			cpuReadData <= respondData;
	end

endmodule

/* cachePkg.sv */
//////////////////////////////
// Read cache shared types
//////////////////////////////

package cachePkg;

	// geometry
	parameter int AddrWidth    = 32;
	parameter int DataWidth    = 16;
	parameter int NumWays      = 4;
	parameter int NumSets      = 8;
	parameter int WordsPerLine = 8;

	// address fields, cpu address split as tag | index | word | byte
	typedef logic [DataWidth-1:0] dataT;          // one bus word
	typedef logic [24:0]          tagT;           // addr[31:7]
	typedef logic [2:0]           indexT;         // addr[6:4]
	typedef logic [2:0]           wordIdxT;       // addr[3:1]
	typedef logic [1:0]           wayT;           // way number 0..3
	typedef logic [2:0]           lruT;           // tree bits of one set

	//////////////////////////////
	// command structs
	//////////////////////////////

	// cpu request as held by the bus port, 50 bits
	typedef struct packed {
		logic    isWrite;                          // 1 = write-through, 0 = read
		tagT     tag;
		indexT   index;
		wordIdxT wordIdx;
		dataT    writeData;
		logic [1:0] byteEnable;                    // [1] upper byte, [0] lower byte
	} cpuCmdT;

	// DRAM opcodes
	typedef enum logic {
		dramBurstRead = 1'b0,                      // eight words, line aligned
		dramWrite     = 1'b1                       // single word
	} dramOpT;

	typedef struct packed {
		dramOpT op;
		logic [AddrWidth-1:0] address;             // bits 3:0 zero on a burst
		dataT   writeData;
		logic [1:0] byteEnable;
	} dramCmdT;

	//////////////////////////////
	// controller FSM
	//////////////////////////////

	typedef enum logic [2:0] {
		stReset,                                   // one cycle out of reset
		stInvalidate,                              // sweep all sets
		stIdle,
		stLookup,                                  // registered hit result valid here
		stHitRespond,
		stFill,                                    // burst line fill in flight
		stFillRespond,
		stWrite                                    // single word write-through
	} ctrlStateT;

endpackage
